/* src/battle_overlay_cfg.svh */
// battle overlay geometry: screen placement, sprite sheet layout and health bar size
`ifndef BATTLE_OVERLAY_CFG_SVH
`define BATTLE_OVERLAY_CFG_SVH

// raster coordinate width
`define SCREEN_BITS 10

// one creature frame on the sheet, and the sheet row pitch
`define SPRITE_W 56
`define SPRITE_H 56
`define SHEET_W  224

// window origins, player creature bottom left, enemy top right
`define TEAM_X  250
`define TEAM_Y  290
`define ENEMY_X 410
`define ENEMY_Y 160

// bar interior size, border sits outside this
`define BAR_W   50
`define BAR_H   5
`define HP_BITS 7

`endif

/* src/battle_geom_pkg.sv */
// geometry and health types shared by the battle overlay datapath
`default_nettype none

`include "battle_overlay_cfg.svh"

package battle_geom_pkg;

   // raster position, x or y
   typedef logic [`SCREEN_BITS-1:0] coord_t;

   // creature index, 8 per sheet (4 rows x 2 pairs)
   typedef logic [2:0] poke_id_t;

   // linear address into the sprite sheet ram
   typedef logic [18:0] sheet_addr_t;

   // current or max health
   typedef logic [`HP_BITS-1:0] hp_t;

   // filled columns of the bar, 0 to BAR_W
   typedef logic [$clog2(`BAR_W+1)-1:0] fill_t;

endpackage

`default_nettype wire

/* src/battle_color_pkg.sv */
// colour type and the health bar palette
`default_nettype none

package battle_color_pkg;

   // 8 bits per channel, red in the top byte
   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb_t;

   // outline around the bar
   localparam rgb_t BAR_BORDER = '{red: 8'h00, green: 8'h00, blue: 8'h00};
   // above half health
   localparam rgb_t BAR_HIGH   = '{red: 8'h41, green: 8'hff, blue: 8'h74};
   // a fifth to a half
   localparam rgb_t BAR_MID    = '{red: 8'h41, green: 8'hcc, blue: 8'h00};
   // a fifth or below
   localparam rgb_t BAR_LOW    = '{red: 8'hff, green: 8'h33, blue: 8'h00};
   // lost health, also the colour when nothing is hit
   localparam rgb_t BAR_EMPTY  = '{red: 8'hff, green: 8'hff, blue: 8'hff};

endpackage

`default_nettype wire

/* src/hp_fill_if.sv */
// fill width request channel between bar shader and divider, four-phase req/ack
`timescale 1ns/100ps
`default_nettype none

interface hp_fill_if;

   // handshake pair
   logic req;
   logic ack;

   // operands, held by the requester while req is high
   battle_geom_pkg::hp_t cur_hp;
   battle_geom_pkg::hp_t max_hp;

   // result, held by the server while ack is high
   battle_geom_pkg::fill_t fill;

   // bar shader side
   modport requester (
      output req, cur_hp, max_hp,
      input  ack, fill
   );

   // divider side
   modport server (
      input  req, cur_hp, max_hp,
      output ack, fill
   );

endinterface

`default_nettype wire

/* src/sprite_addr_gen.sv */
// creature window test and sprite sheet address, two register stages
`timescale 1ns/100ps
`default_nettype none

`include "battle_overlay_cfg.svh"

module sprite_addr_gen #(
   parameter battle_geom_pkg::coord_t ORIGIN_X = `TEAM_X,
   parameter battle_geom_pkg::coord_t ORIGIN_Y = `TEAM_Y,
   // 0 back facing column, 1 front facing column
   parameter bit FACING_COL = 1'b0
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          pix_valid,
   input  battle_geom_pkg::coord_t       draw_x,
   input  battle_geom_pkg::coord_t       draw_y,
   input  battle_geom_pkg::poke_id_t     poke_id,
   output battle_geom_pkg::sheet_addr_t  sprite_addr,
   output logic                          hit
);

   // offset inside one frame, 0 to 55
   localparam int OFS_W = $clog2(`SPRITE_W);

   battle_geom_pkg::coord_t     dx;
   battle_geom_pkg::coord_t     dy;
   logic                        in_win;
   logic                        hit_s1;
   logic [OFS_W-1:0]            dx_s1;
   logic [OFS_W-1:0]            dy_s1;
   logic [1:0]                  frame_col_s1;
   logic [1:0]                  frame_row_s1;
   battle_geom_pkg::sheet_addr_t addr_v;

   // distance from window origin, wraps when left of or above it
   assign dx = draw_x - ORIGIN_X;
   assign dy = draw_y - ORIGIN_Y;

   assign in_win = pix_valid &&
                   draw_x >= ORIGIN_X && dx < battle_geom_pkg::coord_t'(`SPRITE_W) &&
                   draw_y >= ORIGIN_Y && dy < battle_geom_pkg::coord_t'(`SPRITE_H);

   // stage one control
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hit_s1 <= 1'b0;
      end else begin
         hit_s1 <= in_win;
      end
   end

   // stage one offsets and frame position
   always_ff @(posedge clk) begin
      dx_s1        <= dx[OFS_W-1:0];
      dy_s1        <= dy[OFS_W-1:0];
      // pairs of creatures share a sheet row, facing picks the column inside the pair
      frame_col_s1 <= {poke_id[0], FACING_COL};
      frame_row_s1 <= poke_id[2:1];
   end

   // column offset plus row pitch times line on the sheet
   assign addr_v =
      battle_geom_pkg::sheet_addr_t'(frame_col_s1) * battle_geom_pkg::sheet_addr_t'(`SPRITE_W) +
      battle_geom_pkg::sheet_addr_t'(dx_s1) +
      battle_geom_pkg::sheet_addr_t'(`SHEET_W) *
         (battle_geom_pkg::sheet_addr_t'(dy_s1) +
          battle_geom_pkg::sheet_addr_t'(frame_row_s1) *
          battle_geom_pkg::sheet_addr_t'(`SPRITE_H));

   // stage two
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hit <= 1'b0;
      end else begin
         hit <= hit_s1;
      end
   end

   // zero address outside the window
   always_ff @(posedge clk) begin
      sprite_addr <= hit_s1 ? addr_v : '0;
   end

endmodule

`default_nettype wire

/* src/hp_fill_div.sv */
// iterative restoring divider giving the bar fill width BAR_W*cur/max on request
`timescale 1ns/100ps
`default_nettype none

`include "battle_overlay_cfg.svh"

module hp_fill_div (
   input logic       clk,
   input logic       arst_n,
   hp_fill_if.server fill_bus
);

   // dividend bits, 50 * 127 needs 13
   localparam int DIV_W  = $clog2(`BAR_W * (2**`HP_BITS - 1) + 1);
   localparam int FILL_W = $bits(battle_geom_pkg::fill_t);

   typedef enum logic [1:0] {D_IDLE, D_RUN, D_FIN, D_ACK} dstate_t;

   dstate_t              state;
   logic [3:0]           step_cnt;
   logic [DIV_W-1:0]     quo_q;
   battle_geom_pkg::hp_t rem_q;
   battle_geom_pkg::hp_t den_q;
   logic [`HP_BITS:0]    shift_v;
   logic [`HP_BITS+1:0]  trial_v;

   // next dividend bit into the partial remainder, then trial subtract
   assign shift_v = {rem_q, quo_q[DIV_W-1]};
   assign trial_v = {1'b0, shift_v} - {2'b00, den_q};

   // sequencing and ack
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state        <= D_IDLE;
         step_cnt     <= '0;
         fill_bus.ack <= 1'b0;
      end else begin
         case (state)
            D_IDLE: begin
               // operands latched this edge
               if (fill_bus.req) begin
                  state    <= D_RUN;
                  step_cnt <= '0;
               end
            end
            D_RUN: begin
               step_cnt <= step_cnt + 4'd1;
               if (step_cnt == 4'(DIV_W - 1)) begin
                  state <= D_FIN;
               end
            end
            D_FIN: begin
               fill_bus.ack <= 1'b1;
               state        <= D_ACK;
            end
            default: begin
               // hold fill until requester lets go
               if (!fill_bus.req) begin
                  fill_bus.ack <= 1'b0;
                  state        <= D_IDLE;
               end
            end
         endcase
      end
   end

   // datapath
   always_ff @(posedge clk) begin
      case (state)
         D_IDLE: begin
            if (fill_bus.req) begin
               quo_q <= DIV_W'(`BAR_W) * DIV_W'(fill_bus.cur_hp);
               rem_q <= '0;
               den_q <= fill_bus.max_hp;
            end
         end
         D_RUN: begin
            // quotient bits shift in where dividend bits leave
            if (!trial_v[`HP_BITS+1]) begin
               rem_q <= trial_v[`HP_BITS-1:0];
               quo_q <= {quo_q[DIV_W-2:0], 1'b1};
            end else begin
               rem_q <= shift_v[`HP_BITS-1:0];
               quo_q <= {quo_q[DIV_W-2:0], 1'b0};
            end
         end
         D_FIN: begin
            // no max health, empty bar
            if (den_q == '0) begin
               fill_bus.fill <= '0;
            // overheal saturates at full width
            end else if (quo_q > DIV_W'(`BAR_W)) begin
               fill_bus.fill <= battle_geom_pkg::fill_t'(`BAR_W);
            end else begin
               fill_bus.fill <= quo_q[FILL_W-1:0];
            end
         end
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

/* src/hp_bar_shade.sv */
// health bar shader, fetches fill width on health change and colours pixels in two stages
`timescale 1ns/100ps
`default_nettype none

`include "battle_overlay_cfg.svh"

module hp_bar_shade (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     pix_valid,
   input  battle_geom_pkg::coord_t  draw_x,
   input  battle_geom_pkg::coord_t  draw_y,
   input  battle_geom_pkg::coord_t  bar_x,
   input  battle_geom_pkg::coord_t  bar_y,
   input  battle_geom_pkg::hp_t     cur_hp,
   input  battle_geom_pkg::hp_t     max_hp,
   hp_fill_if.requester             fill_bus,
   output battle_color_pkg::rgb_t   bar_rgb,
   output logic                     hit
);

   typedef enum logic [1:0] {H_IDLE, H_REQ, H_DROP} hstate_t;
   typedef enum logic [1:0] {R_NONE, R_BORDER, R_FILL, R_EMPTY} region_t;

   hstate_t                 hstate;
   logic                    synced;
   logic                    issue;
   battle_geom_pkg::hp_t    last_cur;
   battle_geom_pkg::hp_t    last_max;
   battle_geom_pkg::fill_t  fill_q;
   battle_geom_pkg::coord_t rx;
   battle_geom_pkg::coord_t ry;
   logic                    in_box;
   logic                    on_edge;
   region_t                 region;
   region_t                 region_s1;
   battle_geom_pkg::fill_t  fill_s1;

   // new request when idle and health moved, or first time out of reset
   assign issue = (hstate == H_IDLE) &&
                  (!synced || cur_hp != last_cur || max_hp != last_max);

   assign fill_bus.cur_hp = last_cur;
   assign fill_bus.max_hp = last_max;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hstate       <= H_IDLE;
         synced       <= 1'b0;
         fill_bus.req <= 1'b0;
         fill_q       <= '0;
      end else begin
         case (hstate)
            H_IDLE: begin
               if (issue) begin
                  fill_bus.req <= 1'b1;
                  synced       <= 1'b1;
                  hstate       <= H_REQ;
               end
            end
            H_REQ: begin
               // old width stays in use until here
               if (fill_bus.ack) begin
                  fill_q       <= fill_bus.fill;
                  fill_bus.req <= 1'b0;
                  hstate       <= H_DROP;
               end
            end
            default: begin
               if (!fill_bus.ack) begin
                  hstate <= H_IDLE;
               end
            end
         endcase
      end
   end

   // operands frozen for the whole request
   always_ff @(posedge clk) begin
      if (issue) begin
         last_cur <= cur_hp;
         last_max <= max_hp;
      end
   end

   // position relative to the border corner at bar_x-1, bar_y-1
   assign rx = draw_x - bar_x + battle_geom_pkg::coord_t'(1);
   assign ry = draw_y - bar_y + battle_geom_pkg::coord_t'(1);

   assign in_box  = rx <= battle_geom_pkg::coord_t'(`BAR_W + 1) &&
                    ry <= battle_geom_pkg::coord_t'(`BAR_H + 1);
   assign on_edge = rx == '0 || rx == battle_geom_pkg::coord_t'(`BAR_W + 1) ||
                    ry == '0 || ry == battle_geom_pkg::coord_t'(`BAR_H + 1);

   always_comb begin
      if (!pix_valid || !in_box) begin
         region = R_NONE;
      end else if (on_edge) begin
         region = R_BORDER;
      // interior columns 1..fill are filled
      end else if (rx <= battle_geom_pkg::coord_t'(fill_q)) begin
         region = R_FILL;
      end else begin
         region = R_EMPTY;
      end
   end

   // stage one
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         region_s1 <= R_NONE;
         hit       <= 1'b0;
      end else begin
         region_s1 <= region;
         hit       <= region_s1 != R_NONE;
      end
   end

   // width travels with the pixel so a late update cannot split it
   always_ff @(posedge clk) begin
      fill_s1 <= fill_q;
   end

   // stage two colour, bands checked high first
   always_ff @(posedge clk) begin
      case (region_s1)
         R_BORDER: bar_rgb <= battle_color_pkg::BAR_BORDER;
         R_FILL: begin
            if ({fill_s1, 1'b0} > 7'(`BAR_W)) begin
               bar_rgb <= battle_color_pkg::BAR_HIGH;
            end else if (9'(fill_s1) * 9'd5 > 9'(`BAR_W)) begin
               bar_rgb <= battle_color_pkg::BAR_MID;
            end else begin
               bar_rgb <= battle_color_pkg::BAR_LOW;
            end
         end
         default: bar_rgb <= battle_color_pkg::BAR_EMPTY;
      endcase
   end

endmodule

`default_nettype wire

/* src/battle_overlay.sv */
// battle screen overlay top, creature sprite addresses and health bar colour per pixel
`timescale 1ns/100ps
`default_nettype none

`include "battle_overlay_cfg.svh"

module battle_overlay (
   input  logic                          clk,
   input  logic                          arst_n,
   // raster in, one pixel per clock
   input  logic                          pix_valid,
   input  battle_geom_pkg::coord_t       draw_x,
   input  battle_geom_pkg::coord_t       draw_y,
   // battle state
   input  battle_geom_pkg::poke_id_t     team_id,
   input  battle_geom_pkg::poke_id_t     enemy_id,
   input  battle_geom_pkg::hp_t          cur_hp,
   input  battle_geom_pkg::hp_t          max_hp,
   input  battle_geom_pkg::coord_t       bar_x,
   input  battle_geom_pkg::coord_t       bar_y,
   // results, two clocks after the pixel
   output logic                          out_valid,
   output battle_geom_pkg::sheet_addr_t  team_addr,
   output logic                          is_team,
   output battle_geom_pkg::sheet_addr_t  enemy_addr,
   output logic                          is_enemy,
   output battle_color_pkg::rgb_t        bar_rgb,
   output logic                          is_bar
);

   logic [1:0] valid_pipe;

   hp_fill_if fill_bus ();

   // player creature, back view
   sprite_addr_gen #(
      .ORIGIN_X   (battle_geom_pkg::coord_t'(`TEAM_X)),
      .ORIGIN_Y   (battle_geom_pkg::coord_t'(`TEAM_Y)),
      .FACING_COL (1'b0)
   ) team_gen (
      .clk         (clk),
      .arst_n      (arst_n),
      .pix_valid   (pix_valid),
      .draw_x      (draw_x),
      .draw_y      (draw_y),
      .poke_id     (team_id),
      .sprite_addr (team_addr),
      .hit         (is_team)
   );

   // enemy creature, front view
   sprite_addr_gen #(
      .ORIGIN_X   (battle_geom_pkg::coord_t'(`ENEMY_X)),
      .ORIGIN_Y   (battle_geom_pkg::coord_t'(`ENEMY_Y)),
      .FACING_COL (1'b1)
   ) enemy_gen (
      .clk         (clk),
      .arst_n      (arst_n),
      .pix_valid   (pix_valid),
      .draw_x      (draw_x),
      .draw_y      (draw_y),
      .poke_id     (enemy_id),
      .sprite_addr (enemy_addr),
      .hit         (is_enemy)
   );

   hp_bar_shade bar_shade (
      .clk       (clk),
      .arst_n    (arst_n),
      .pix_valid (pix_valid),
      .draw_x    (draw_x),
      .draw_y    (draw_y),
      .bar_x     (bar_x),
      .bar_y     (bar_y),
      .cur_hp    (cur_hp),
      .max_hp    (max_hp),
      .fill_bus  (fill_bus.requester),
      .bar_rgb   (bar_rgb),
      .hit       (is_bar)
   );

   hp_fill_div fill_div (
      .clk      (clk),
      .arst_n   (arst_n),
      .fill_bus (fill_bus.server)
   );

   // valid matches the two pipeline stages of the generators
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_pipe <= '0;
      end else begin
         valid_pipe <= {valid_pipe[0], pix_valid};
      end
   end

   assign out_valid = valid_pipe[1];

endmodule

`default_nettype wire

/* tests/battle_overlay_assert.sv */
// pipeline and fill handshake properties for the battle overlay
`timescale 1ns/100ps
`default_nettype none

module battle_overlay_assert (
   input logic clk,
   input logic arst_n,
   input logic pix_valid,
   input logic out_valid,
   input logic is_team,
   input logic is_enemy,
   input logic req,
   input logic ack
);

   // read back by the testbench at the end of the run
   int fail_cnt = 0;

   // out_valid is pix_valid two clocks late
   valid_rise: assert property (@(posedge clk) disable iff (!arst_n)
      pix_valid |-> ##2 out_valid)
      else begin
         fail_cnt++;
         $error("out_valid low two cycles after a valid pixel");
      end

   valid_gap: assert property (@(posedge clk) disable iff (!arst_n)
      !pix_valid |-> ##2 !out_valid)
      else begin
         fail_cnt++;
         $error("out_valid high two cycles after a gap");
      end

   // windows never overlap
   one_creature: assert property (@(posedge clk) disable iff (!arst_n)
      !(is_team && is_enemy))
      else begin
         fail_cnt++;
         $error("is_team and is_enemy high together");
      end

   // four-phase rules
   req_hold: assert property (@(posedge clk) disable iff (!arst_n)
      req && !ack |=> req)
      else begin
         fail_cnt++;
         $error("req dropped before ack");
      end

   ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(ack) |-> req)
      else begin
         fail_cnt++;
         $error("ack rose without req");
      end

   ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
      !req && ack |=> !ack)
      else begin
         fail_cnt++;
         $error("ack held after req fell");
      end

endmodule

bind battle_overlay battle_overlay_assert assert_i (
   .clk       (clk),
   .arst_n    (arst_n),
   .pix_valid (pix_valid),
   .out_valid (out_valid),
   .is_team   (is_team),
   .is_enemy  (is_enemy),
   .req       (fill_bus.req),
   .ack       (fill_bus.ack)
);

`default_nettype wire

/* tests/battle_overlay_tb.sv */
// testbench for the battle overlay, reference model and directed pixel tests
`timescale 1ns/100ps
`default_nettype none

`include "battle_overlay_cfg.svh"

module battle_overlay_tb;

   // bar placement, well away from both creature windows
   localparam int BAR_X0 = 100;
   localparam int BAR_Y0 = 40;

   typedef struct {
      logic                   valid;
      int                     x;
      int                     y;
      int                     tid;
      int                     eid;
      battle_geom_pkg::fill_t fill;
   } pix_t;

   logic                         clk;
   logic                         arst_n;
   logic                         pix_valid;
   battle_geom_pkg::coord_t      draw_x;
   battle_geom_pkg::coord_t      draw_y;
   battle_geom_pkg::poke_id_t    team_id;
   battle_geom_pkg::poke_id_t    enemy_id;
   battle_geom_pkg::hp_t         cur_hp;
   battle_geom_pkg::hp_t         max_hp;
   battle_geom_pkg::coord_t      bar_x;
   battle_geom_pkg::coord_t      bar_y;
   logic                         out_valid;
   battle_geom_pkg::sheet_addr_t team_addr;
   logic                         is_team;
   battle_geom_pkg::sheet_addr_t enemy_addr;
   logic                         is_enemy;
   battle_color_pkg::rgb_t       bar_rgb;
   logic                         is_bar;

   int                     check_cnt = 0;
   int                     err_cnt = 0;
   int                     timeout_cnt = 0;
   int                     total_err;
   logic                   mon_en = 1'b0;
   logic [31:0]            lcg_state = 32'd53022;
   battle_geom_pkg::fill_t model_fill;
   pix_t                   pix_q[$];
   pix_t                   cur_pix;
   pix_t                   old_pix;

   battle_overlay battle_overlay_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .pix_valid  (pix_valid),
      .draw_x     (draw_x),
      .draw_y     (draw_y),
      .team_id    (team_id),
      .enemy_id   (enemy_id),
      .cur_hp     (cur_hp),
      .max_hp     (max_hp),
      .bar_x      (bar_x),
      .bar_y      (bar_y),
      .out_valid  (out_valid),
      .team_addr  (team_addr),
      .is_team    (is_team),
      .enemy_addr (enemy_addr),
      .is_enemy   (is_enemy),
      .bar_rgb    (bar_rgb),
      .is_bar     (is_bar)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // lcg, upper bits only
   function automatic int rand_below(input int n);
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return int'((lcg_state >> 8) % n);
   endfunction

   // fill width is BAR_W * cur / max, clamped, zero without max
   function automatic battle_geom_pkg::fill_t fill_model(input int c, input int m);
      int q;
      q = 0;
      if (m != 0) begin
         q = (`BAR_W * c) / m;
      end
      if (q > `BAR_W) begin
         q = `BAR_W;
      end
      return battle_geom_pkg::fill_t'(q);
   endfunction

   // frame column from id pair and facing, frame row from id / 2
   function automatic void sprite_model(input logic v, input int x, input int y,
         input int ox, input int oy, input int id, input int facing,
         output battle_geom_pkg::sheet_addr_t addr, output logic hit);
      int col;
      int row;
      col = 2 * (id % 2) + facing;
      row = id / 2;
      hit = v && x >= ox && x < ox + `SPRITE_W && y >= oy && y < oy + `SPRITE_H;
      addr = '0;
      if (hit) begin
         addr = battle_geom_pkg::sheet_addr_t'(col * `SPRITE_W + (x - ox) +
                `SHEET_W * ((y - oy) + row * `SPRITE_H));
      end
   endfunction

   // box of (BAR_W+2) x (BAR_H+2) with corner at bar_x-1, bar_y-1
   function automatic void bar_model(input logic v, input int x, input int y, input int f,
         output battle_color_pkg::rgb_t rgb, output logic hit);
      int rx;
      int ry;
      rx = x - BAR_X0 + 1;
      ry = y - BAR_Y0 + 1;
      rgb = battle_color_pkg::BAR_EMPTY;
      hit = v && rx >= 0 && rx <= `BAR_W + 1 && ry >= 0 && ry <= `BAR_H + 1;
      if (hit && (rx == 0 || rx == `BAR_W + 1 || ry == 0 || ry == `BAR_H + 1)) begin
         rgb = battle_color_pkg::BAR_BORDER;
      end else if (hit && rx <= f) begin
         // colour bands, high first
         if (2 * f > `BAR_W) begin
            rgb = battle_color_pkg::BAR_HIGH;
         end else if (5 * f > `BAR_W) begin
            rgb = battle_color_pkg::BAR_MID;
         end else begin
            rgb = battle_color_pkg::BAR_LOW;
         end
      end
   endfunction

   task automatic check_sprite(input string what, input battle_geom_pkg::sheet_addr_t got,
         input logic got_hit, input battle_geom_pkg::sheet_addr_t exp, input logic exp_hit);
      check_cnt++;
      if (got !== exp || got_hit !== exp_hit) begin
         err_cnt++;
         $display("mismatch at %0t: %s addr %0d hit %b, expected addr %0d hit %b",
                  $time, what, got, got_hit, exp, exp_hit);
      end
   endtask

   task automatic check_bar(input battle_color_pkg::rgb_t got, input logic got_hit,
         input battle_color_pkg::rgb_t exp, input logic exp_hit);
      check_cnt++;
      if (got !== exp || got_hit !== exp_hit) begin
         err_cnt++;
         $display("mismatch at %0t: bar rgb %h hit %b, expected rgb %h hit %b",
                  $time, got, got_hit, exp, exp_hit);
      end
   endtask

   task automatic check_valid(input logic got, input logic exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("mismatch at %0t: out_valid %b, expected %b", $time, got, exp);
      end
   endtask

   // all four results against the pixel sent two cycles earlier
   task automatic compare_outputs(input pix_t p);
      battle_geom_pkg::sheet_addr_t exp_addr;
      logic                         exp_hit;
      battle_color_pkg::rgb_t       exp_rgb;
      check_valid(out_valid, p.valid);
      sprite_model(p.valid, p.x, p.y, `TEAM_X, `TEAM_Y, p.tid, 0, exp_addr, exp_hit);
      check_sprite("team", team_addr, is_team, exp_addr, exp_hit);
      sprite_model(p.valid, p.x, p.y, `ENEMY_X, `ENEMY_Y, p.eid, 1, exp_addr, exp_hit);
      check_sprite("enemy", enemy_addr, is_enemy, exp_addr, exp_hit);
      bar_model(p.valid, p.x, p.y, int'(p.fill), exp_rgb, exp_hit);
      check_bar(bar_rgb, is_bar, exp_rgb, exp_hit);
   endtask

   // inputs and outputs both settled at the falling edge
   always @(negedge clk) begin
      if (mon_en) begin
         cur_pix.valid = pix_valid;
         cur_pix.x = int'(draw_x);
         cur_pix.y = int'(draw_y);
         cur_pix.tid = int'(team_id);
         cur_pix.eid = int'(enemy_id);
         cur_pix.fill = model_fill;
         if (pix_q.size() == 2) begin
            old_pix = pix_q.pop_front();
            compare_outputs(old_pix);
         end
         pix_q.push_back(cur_pix);
      end
   end

   task automatic wait_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
      end
   endtask

   task automatic send_pixel(input logic v, input int x, input int y,
         input int tid, input int eid);
      @(posedge clk);
      pix_valid <= v;
      draw_x    <= battle_geom_pkg::coord_t'(x);
      draw_y    <= battle_geom_pkg::coord_t'(y);
      team_id   <= battle_geom_pkg::poke_id_t'(tid);
      enemy_id  <= battle_geom_pkg::poke_id_t'(eid);
   endtask

   // raster idle while the divider catches up
   task automatic set_health(input int c, input int m);
      @(posedge clk);
      pix_valid  <= 1'b0;
      cur_hp     <= battle_geom_pkg::hp_t'(c);
      max_hp     <= battle_geom_pkg::hp_t'(m);
      model_fill = fill_model(c, m);
      wait_cycles(30);
   endtask

   // corners, centre and one past each edge, for every id
   task automatic probe_window(input int ox, input int oy, input logic enemy);
      int dx_list[9] = '{0, 55, 0, 55, 28, -1, 56, 28, 28};
      int dy_list[9] = '{0, 0, 55, 55, 28, 28, 28, -1, 56};
      for (int id = 0; id < 8; id++) begin
         for (int k = 0; k < 9; k++) begin
            send_pixel(1'b1, ox + dx_list[k], oy + dy_list[k], enemy ? 0 : id, enemy ? id : 0);
         end
      end
   endtask

   // outline rows and columns plus the ring just outside
   task automatic border_ring();
      for (int x = BAR_X0 - 2; x <= BAR_X0 + `BAR_W + 1; x++) begin
         send_pixel(1'b1, x, BAR_Y0 - 1, 0, 0);
         send_pixel(1'b1, x, BAR_Y0 + `BAR_H, 0, 0);
         send_pixel(1'b1, x, BAR_Y0 - 2, 0, 0);
         send_pixel(1'b1, x, BAR_Y0 + `BAR_H + 1, 0, 0);
      end
      for (int y = BAR_Y0 - 2; y <= BAR_Y0 + `BAR_H + 1; y++) begin
         send_pixel(1'b1, BAR_X0 - 1, y, 0, 0);
         send_pixel(1'b1, BAR_X0 + `BAR_W, y, 0, 0);
         send_pixel(1'b1, BAR_X0 - 2, y, 0, 0);
         send_pixel(1'b1, BAR_X0 + `BAR_W + 1, y, 0, 0);
      end
   endtask

   // one health level, then a full row across the fill boundary
   task automatic shade_level(input int c, input int m);
      set_health(c, m);
      for (int x = BAR_X0 - 1; x <= BAR_X0 + `BAR_W; x++) begin
         send_pixel(1'b1, x, BAR_Y0 + 2, 0, 0);
      end
   endtask

   task automatic health_bands();
      shade_level(100, 100);
      // overheal clamps to full
      shade_level(127, 90);
      shade_level(52, 100);
      shade_level(51, 100);
      shade_level(40, 100);
      shade_level(22, 100);
      shade_level(21, 100);
      shade_level(7, 100);
      shade_level(1, 127);
      shade_level(30, 0);
   endtask

   // 200 back to back, then valid gaps
   task automatic random_stream();
      int sel;
      int x;
      int y;
      logic v;
      set_health(60, 100);
      for (int i = 0; i < 300; i++) begin
         sel = rand_below(4);
         v = (i < 200) ? 1'b1 : logic'(rand_below(2));
         case (sel)
            0: begin
               x = `TEAM_X - 4 + rand_below(64);
               y = `TEAM_Y - 4 + rand_below(64);
            end
            1: begin
               x = `ENEMY_X - 4 + rand_below(64);
               y = `ENEMY_Y - 4 + rand_below(64);
            end
            2: begin
               x = BAR_X0 - 3 + rand_below(56);
               y = BAR_Y0 - 3 + rand_below(11);
            end
            default: begin
               x = rand_below(1024);
               y = rand_below(1024);
            end
         endcase
         send_pixel(v, x, y, rand_below(8), rand_below(8));
      end
   endtask

   // stop the raster and let the last pixels reach the checks
   task automatic drain_pipe();
      int n;
      @(posedge clk);
      pix_valid <= 1'b0;
      n = 0;
      @(negedge clk);
      while (out_valid !== 1'b0 && n < 8) begin
         @(negedge clk);
         n++;
      end
      if (out_valid !== 1'b0) begin
         timeout_cnt++;
         $display("timeout: out_valid still high 8 cycles after the raster stopped");
      end
   endtask

   initial begin
      arst_n     = 1'b0;
      pix_valid  = 1'b0;
      draw_x     = '0;
      draw_y     = '0;
      team_id    = '0;
      enemy_id   = '0;
      cur_hp     = battle_geom_pkg::hp_t'(100);
      max_hp     = battle_geom_pkg::hp_t'(100);
      bar_x      = battle_geom_pkg::coord_t'(BAR_X0);
      bar_y      = battle_geom_pkg::coord_t'(BAR_Y0);
      model_fill = fill_model(100, 100);
      wait_cycles(16);
      arst_n <= 1'b1;
      mon_en = 1'b1;
      // first request goes out right after reset
      set_health(100, 100);
      probe_window(`TEAM_X, `TEAM_Y, 1'b0);
      probe_window(`ENEMY_X, `ENEMY_Y, 1'b1);
      border_ring();
      health_bands();
      random_stream();
      drain_pipe();
      wait_cycles(2);
      total_err = err_cnt + timeout_cnt + battle_overlay_i.assert_i.fail_cnt;
      $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
               check_cnt, err_cnt, timeout_cnt, battle_overlay_i.assert_i.fail_cnt);
      if (total_err == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* battle_overlay.f */
+incdir+src
src/battle_geom_pkg.sv
src/battle_color_pkg.sv
src/hp_fill_if.sv
src/sprite_addr_gen.sv
src/hp_fill_div.sv
src/hp_bar_shade.sv
src/battle_overlay.sv
tests/battle_overlay_assert.sv
tests/battle_overlay_tb.sv
